// ==== files.f ====
+incdir+include
verilog/archer_pkg.sv
verilog/archer_game_fsm.sv
verilog/archer_fire_timer.sv
verilog/archer_aim_unit.sv
verilog/archer_projectile_pool.sv
verilog/archer_top.sv
test/archer_clock_gen.sv
test/archer_tb.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module archer_tb -o archer_sim
./obj_dir/archer_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi

// ==== test/archer_tb.sv ====
`include "archer_settings.svh"

module archer_tb import archer_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {ACT_START, ACT_FIRE, ACT_RFIRE, ACT_FRAMES} act_t;
    typedef struct {
        act_t   act;
        point_t mouse;
        point_t origin;
        int     frames;
        int     exp_count;
    } row_t;

    logic clk, rst, start, frame_tick, mouse_clicked;
    point_t mouse, origin, boss;
    point_t [`ARCHER_SLOTS-1:0] proj_pos;
    logic [`ARCHER_SLOTS-1:0] proj_active;
    logic projectile_hit;
    game_state_t game_state;

    row_t rows[$];
    int errors = 0;
    int cycles = 0;
    int limit = 1000000;

    // reference model state
    int m_act[`ARCHER_SLOTS], m_x[`ARCHER_SLOTS], m_y[`ARCHER_SLOTS];
    int m_sx[`ARCHER_SLOTS], m_sy[`ARCHER_SLOTS], m_life[`ARCHER_SLOTS];
    int m_timer = 0;
    int m_health = 0;
    game_state_t m_state = GAME_IDLE;

    archer_clock_gen clock0 (.clk(clk), .rst(rst));

    archer_top dut0 (
        .clk(clk), .rst(rst), .start(start), .frame_tick(frame_tick),
        .mouse_clicked(mouse_clicked), .mouse(mouse), .origin(origin), .boss(boss),
        .proj_pos(proj_pos), .proj_active(proj_active),
        .projectile_hit(projectile_hit), .game_state(game_state)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_row(act_t a, int mx, int my, int ox, int oy, int f, int c);
        row_t r;
        r.act = a;
        r.mouse = '{x: 12'(mx), y: 12'(my)};
        r.origin = '{x: 12'(ox), y: 12'(oy)};
        r.frames = f;
        r.exp_count = c;
        rows.push_back(r);
    endtask

    task automatic model_fire(point_t ms, point_t org);
        int dx, dy, mx;
        dx = int'(ms.x) - int'(org.x);
        dy = int'(ms.y) - int'(org.y);
        mx = (dx < 0 ? -dx : dx) > (dy < 0 ? -dy : dy) ? (dx < 0 ? -dx : dx) : (dy < 0 ? -dy : dy);
        if (m_state != GAME_PLAY || m_timer != 0)
            return;
        m_timer = `ARCHER_COOLDOWN;
        for (int i = 0; i < `ARCHER_SLOTS; i++) begin
            if (!m_act[i]) begin
                m_act[i] = 1;
                m_x[i] = org.x;
                m_y[i] = org.y;
                m_sx[i] = (mx == 0) ? 0 : dx * `ARCHER_SPEED / mx;
                m_sy[i] = (mx == 0) ? 0 : dy * `ARCHER_SPEED / mx;
                m_life[i] = `ARCHER_LIFETIME;
                return;
            end
        end
    endtask

    // one frame of the model, returns whether any arrow hit
    function automatic int model_tick();
        int hit, nx, ny, alive, in_box;
        hit = 0;
        alive = (m_state == GAME_PLAY) && (m_health > 0);
        for (int i = 0; i < `ARCHER_SLOTS; i++) begin
            nx = m_x[i] + m_sx[i];
            ny = m_y[i] + m_sy[i];
            in_box = (m_x[i] >= int'(boss.x) - `ARCHER_BOSS_HALF_W) &&
                     (m_x[i] <= int'(boss.x) + `ARCHER_BOSS_HALF_W) &&
                     (m_y[i] >= int'(boss.y) - `ARCHER_BOSS_HALF_H) &&
                     (m_y[i] <= int'(boss.y) + `ARCHER_BOSS_HALF_H);
            if (!m_act[i])
                continue;
            if (m_life[i] == 0)
                m_act[i] = 0;
            else if (m_x[i] > `ARCHER_SCREEN_W || m_y[i] > `ARCHER_SCREEN_H ||
                     nx < 0 || nx > 4095 || ny < 0 || ny > 4095)
                m_act[i] = 0;
            else if (alive && in_box) begin
                m_act[i] = 0;
                hit = 1;
            end else begin
                m_x[i] = nx;
                m_y[i] = ny;
                m_life[i]--;
            end
        end
        if (m_timer > 0)
            m_timer--;
        if (hit) begin
            m_health--;
            if (m_health == 0) begin
                m_state = GAME_WON;
                for (int i = 0; i < `ARCHER_SLOTS; i++)
                    m_act[i] = 0;
            end
        end
        return hit;
    endfunction

    task automatic run_frame();
        int hit;
        hit = model_tick();
        frame_tick = 1'b1;
        @(negedge clk);
        frame_tick = 1'b0;
        assert (projectile_hit === 1'(hit))
        else begin
            errors++;
            $display("CHECK FAILED projectile_hit: got %h expected %h", projectile_hit, hit);
        end
        // the hit pulse lasts a single cycle
        @(negedge clk);
        assert (projectile_hit === 1'b0)
        else begin
            errors++;
            $display("CHECK FAILED projectile_hit: got %h expected %h after pulse",
                     projectile_hit, 1'b0);
        end
        repeat (6) @(negedge clk);
    endtask

    task automatic compare_outputs(int ridx, int exp_count);
        assert (game_state === m_state)
        else begin
            errors++;
            $display("CHECK FAILED row %0d game_state: got %h expected %h",
                     ridx, game_state, m_state);
        end
        assert (projectile_hit === 1'b0)
        else begin
            errors++;
            $display("CHECK FAILED row %0d projectile_hit: got %h expected %h",
                     ridx, projectile_hit, 1'b0);
        end
        for (int i = 0; i < `ARCHER_SLOTS; i++) begin
            assert (proj_active[i] === 1'(m_act[i]))
            else begin
                errors++;
                $display("CHECK FAILED row %0d proj_active[%0d]: got %h expected %h",
                         ridx, i, proj_active[i], m_act[i]);
            end
            if (m_act[i]) begin
                assert (proj_pos[i] === {12'(m_x[i]), 12'(m_y[i])})
                else begin
                    errors++;
                    $display("CHECK FAILED row %0d proj_pos[%0d]: got %h expected %h",
                             ridx, i, proj_pos[i], {12'(m_x[i]), 12'(m_y[i])});
                end
            end
        end
        if (exp_count >= 0) begin
            assert ($countones(proj_active) == exp_count)
            else begin
                errors++;
                $display("CHECK FAILED row %0d active count: got %h expected %h",
                         ridx, $countones(proj_active), exp_count);
            end
        end
    endtask

    initial begin
        row_t r;
        int total;
        void'($urandom(6));
        start = 1'b0;
        frame_tick = 1'b0;
        mouse_clicked = 1'b0;
        mouse = '0;
        origin = '0;
        boss = '{x: 12'd800, y: 12'd100};
        for (int i = 0; i < `ARCHER_SLOTS; i++)
            m_act[i] = 0;

        // idle click, then four rightward arrows to fill the pool
        add_row(ACT_FIRE, 1000, 700, 0, 700, 0, 0);
        add_row(ACT_START, 0, 0, 0, 0, 0, 0);
        add_row(ACT_FIRE, 1000, 700, 0, 700, 0, 1);
        add_row(ACT_FRAMES, 0, 0, 0, 0, 3, 1);
        add_row(ACT_FIRE, 1000, 700, 0, 700, 0, 1);
        add_row(ACT_FRAMES, 0, 0, 0, 0, 12, 1);
        for (int k = 0; k < 3; k++) begin
            add_row(ACT_FIRE, 1000, 700, 0, 700, 0, 2 + k);
            add_row(ACT_FRAMES, 0, 0, 0, 0, 15, 2 + k);
        end
        add_row(ACT_FIRE, 1000, 700, 0, 700, 0, 4);
        add_row(ACT_FRAMES, 0, 0, 0, 0, 1, 3);
        add_row(ACT_FRAMES, 0, 0, 0, 0, 14, 3);
        add_row(ACT_FRAMES, 0, 0, 0, 0, 1, 2);
        // three arrows straight up into the boss
        for (int k = 0; k < 3; k++) begin
            add_row(ACT_FIRE, 800, 100, 800, 700, 0, -1);
            add_row(ACT_FRAMES, 0, 0, 0, 0, 15, -1);
        end
        add_row(ACT_FRAMES, 0, 0, 0, 0, 25, 0);
        add_row(ACT_START, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 3; k++) begin
            add_row(ACT_RFIRE, 0, 0, 100, 700, 0, -1);
            add_row(ACT_FRAMES, 0, 0, 0, 0, 15, -1);
        end
        add_row(ACT_FRAMES, 0, 0, 0, 0, 70, 0);

        total = 10;
        foreach (rows[i])
            total += rows[i].frames * 8 + 8;
        limit = total + 200;

        @(negedge rst);
        @(negedge clk);
        compare_outputs(-1, 0);
        foreach (rows[i]) begin
            r = rows[i];
            case (r.act)
                ACT_START: begin
                    if (m_state != GAME_PLAY) begin
                        m_state = GAME_PLAY;
                        m_health = `ARCHER_BOSS_HEALTH;
                    end
                    start = 1'b1;
                    @(negedge clk);
                    start = 1'b0;
                    repeat (2) @(negedge clk);
                end
                ACT_FIRE, ACT_RFIRE: begin
                    if (r.act == ACT_RFIRE)
                        r.mouse = '{x: 12'($urandom % 100), y: 12'($urandom % 768)};
                    model_fire(r.mouse, r.origin);
                    mouse = r.mouse;
                    origin = r.origin;
                    mouse_clicked = 1'b1;
                    @(negedge clk);
                    mouse_clicked = 1'b0;
                    repeat (3) @(negedge clk);
                end
                default: begin
                    repeat (r.frames) run_frame();
                end
            endcase
            compare_outputs(i, r.exp_count);
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== test/archer_clock_gen.sv ====
module archer_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for ten clock cycles
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== verilog/archer_top.sv ====
`include "archer_settings.svh"

module archer_top import archer_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          frame_tick,
    input  logic                          mouse_clicked,
    input  point_t                        mouse,
    input  point_t                        origin,
    input  point_t                        boss,
    output point_t [`ARCHER_SLOTS-1:0]    proj_pos,
    output logic   [`ARCHER_SLOTS-1:0]    proj_active,
    output logic                          projectile_hit,
    output game_state_t                   game_state
);

    logic  boss_alive;
    logic  timer_ready;
    logic  fire_accept;
    shot_t shot;

    // clicks only count in play and after the cooldown
    assign fire_accept = mouse_clicked && timer_ready && (game_state == GAME_PLAY);

    archer_game_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .projectile_hit (projectile_hit),
        .game_state     (game_state),
        .boss_alive     (boss_alive)
    );

    archer_fire_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .frame_tick  (frame_tick),
        .fire_accept (fire_accept),
        .ready       (timer_ready)
    );

    archer_aim_unit u_aim (
        .clk         (clk),
        .rst         (rst),
        .fire_accept (fire_accept),
        .mouse       (mouse),
        .origin      (origin),
        .shot        (shot)
    );

    archer_projectile_pool u_pool (
        .clk            (clk),
        .rst            (rst),
        .frame_tick     (frame_tick),
        .game_state     (game_state),
        .boss_alive     (boss_alive),
        .boss           (boss),
        .shot           (shot),
        .proj_pos       (proj_pos),
        .proj_active    (proj_active),
        .projectile_hit (projectile_hit)
    );

endmodule

// ==== verilog/archer_projectile_pool.sv ====
`include "archer_settings.svh"

module archer_projectile_pool import archer_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          frame_tick,
    input  game_state_t                   game_state,
    input  logic                          boss_alive,
    input  point_t                        boss,
    input  shot_t                         shot,
    output point_t [`ARCHER_SLOTS-1:0]    proj_pos,
    output logic   [`ARCHER_SLOTS-1:0]    proj_active,
    output logic                          projectile_hit
);

    localparam int N  = `ARCHER_SLOTS;
    localparam int LW = $clog2(`ARCHER_LIFETIME + 1);

    logic signed [5:0] step_x [N];
    logic signed [5:0] step_y [N];
    logic [LW-1:0]     life [N];

    logic              play;
    logic [N-1:0]      free;
    logic [N-1:0]      load_sel;
    logic [N-1:0]      kill;
    logic [N-1:0]      hit_vec;
    point_t            moved [N];

    // boss box bounds, widened so that edges near zero do not wrap
    logic signed [13:0] box_xlo;
    logic signed [13:0] box_xhi;
    logic signed [13:0] box_ylo;
    logic signed [13:0] box_yhi;

    assign box_xlo = signed'({2'b00, boss.x}) - 14'(`ARCHER_BOSS_HALF_W);
    assign box_xhi = signed'({2'b00, boss.x}) + 14'(`ARCHER_BOSS_HALF_W);
    assign box_ylo = signed'({2'b00, boss.y}) - 14'(`ARCHER_BOSS_HALF_H);
    assign box_yhi = signed'({2'b00, boss.y}) + 14'(`ARCHER_BOSS_HALF_H);

    assign play = (game_state == GAME_PLAY);

    // lowest inactive slot takes the shot
    assign free     = ~proj_active;
    assign load_sel = (shot.valid && play) ? (free & (~free + 1'b1)) : '0;

    for (genvar i = 0; i < N; i++) begin : g_slot
        logic [12:0]        nx;
        logic [12:0]        ny;
        logic signed [13:0] px;
        logic signed [13:0] py;
        logic               off;
        logic               in_box;
        logic               expired;

        assign nx = {1'b0, proj_pos[i].x} + {{7{step_x[i][5]}}, step_x[i]};
        assign ny = {1'b0, proj_pos[i].y} + {{7{step_y[i][5]}}, step_y[i]};
        assign moved[i] = '{x: nx[11:0], y: ny[11:0]};

        // bit 12 set means the step carried out of or borrowed below the 12-bit range
        assign off = (proj_pos[i].x > `ARCHER_SCREEN_W) || (proj_pos[i].y > `ARCHER_SCREEN_H)
                     || nx[12] || ny[12];

        assign px = signed'({2'b00, proj_pos[i].x});
        assign py = signed'({2'b00, proj_pos[i].y});
        assign in_box = (px >= box_xlo) && (px <= box_xhi) &&
                        (py >= box_ylo) && (py <= box_yhi);

        assign expired    = (life[i] == '0);
        assign hit_vec[i] = frame_tick && proj_active[i] && !expired && !off &&
                            boss_alive && in_box;
        assign kill[i]    = expired || off || hit_vec[i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            proj_active    <= '0;
            projectile_hit <= 1'b0;
        end else if (!play) begin
            proj_active    <= '0;
            projectile_hit <= 1'b0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (load_sel[i])
                    proj_active[i] <= 1'b1;
                else if (frame_tick && proj_active[i] && kill[i])
                    proj_active[i] <= 1'b0;
            end
            // one pulse however many arrows hit on this tick
            projectile_hit <= |hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (load_sel[i]) begin
                proj_pos[i] <= shot.origin;
                step_x[i]   <= shot.step_x;
                step_y[i]   <= shot.step_y;
                life[i]     <= LW'(`ARCHER_LIFETIME);
            end else if (frame_tick && proj_active[i]) begin
                proj_pos[i] <= moved[i];
                if (life[i] != '0)
                    life[i] <= life[i] - 1'b1;
            end
        end
    end

    // the aim pipeline delivers at most one shot per cycle
    assert property (@(posedge clk) disable iff (rst)
        $countones(proj_active & ~$past(proj_active)) <= 1)
        else $error("more than one slot allocated in a cycle");

endmodule

// ==== verilog/archer_aim_unit.sv ====
`include "archer_settings.svh"

module archer_aim_unit import archer_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fire_accept,
    input  point_t mouse,
    input  point_t origin,
    output shot_t  shot
);

    // stage 1 registers
    logic               v1;
    logic signed [12:0] dx1;
    logic signed [12:0] dy1;
    logic [11:0]        max1;
    point_t             org1;

    // stage 2 registers
    logic              v2;
    point_t            org2;
    logic signed [5:0] sx2;
    logic signed [5:0] sy2;

    logic signed [12:0] dx;
    logic signed [12:0] dy;
    logic [11:0]        ax;
    logic [11:0]        ay;
    logic signed [17:0] num_x;
    logic signed [17:0] num_y;
    logic signed [17:0] den;
    logic signed [17:0] quot_x;
    logic signed [17:0] quot_y;

    assign dx = signed'({1'b0, mouse.x}) - signed'({1'b0, origin.x});
    assign dy = signed'({1'b0, mouse.y}) - signed'({1'b0, origin.y});
    // magnitudes never exceed 4095
    assign ax = dx[12] ? 12'(-dx) : dx[11:0];
    assign ay = dy[12] ? 12'(-dy) : dy[11:0];

    // both differences zero gives numerators of zero, so any nonzero divisor works
    assign num_x  = 18'(dx1) * 18'(`ARCHER_SPEED);
    assign num_y  = 18'(dy1) * 18'(`ARCHER_SPEED);
    assign den    = (max1 == '0) ? 18'sd1 : signed'({6'b0, max1});
    assign quot_x = num_x / den;
    assign quot_y = num_y / den;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= fire_accept;
            v2 <= v1;
        end
    end

    always_ff @(posedge clk) begin
        dx1  <= dx;
        dy1  <= dy;
        max1 <= (ax > ay) ? ax : ay;
        org1 <= origin;
        org2 <= org1;
        sx2  <= quot_x[5:0];
        sy2  <= quot_y[5:0];
    end

    assign shot = '{valid: v2, origin: org2, step_x: sx2, step_y: sy2};

endmodule

// ==== verilog/archer_fire_timer.sv ====
`include "archer_settings.svh"

module archer_fire_timer (
    input  logic clk,
    input  logic rst,
    input  logic frame_tick,
    input  logic fire_accept,
    output logic ready
);

    localparam int CW = $clog2(`ARCHER_COOLDOWN + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (fire_accept) begin
            count <= CW'(`ARCHER_COOLDOWN);
        end else if (frame_tick && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign ready = (count == '0);

    // the top gates clicks with ready, so no accept may arrive early
    assert property (@(posedge clk) disable iff (rst)
        fire_accept |-> ready)
        else $error("fire accepted during cooldown");

endmodule

// ==== verilog/archer_game_fsm.sv ====
`include "archer_settings.svh"

module archer_game_fsm import archer_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        projectile_hit,
    output game_state_t game_state,
    output logic        boss_alive
);

    localparam int HW = $clog2(`ARCHER_BOSS_HEALTH + 1);

    logic [HW-1:0] health;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= GAME_IDLE;
            health     <= '0;
        end else begin
            case (game_state)
                GAME_IDLE, GAME_WON: begin
                    if (start) begin
                        game_state <= GAME_PLAY;
                        health     <= HW'(`ARCHER_BOSS_HEALTH);
                    end
                end
                GAME_PLAY: begin
                    if (projectile_hit && health != '0) begin
                        health <= health - 1'b1;
                        // last hit ends the round
                        if (health == HW'(1))
                            game_state <= GAME_WON;
                    end
                end
                default: game_state <= GAME_IDLE;
            endcase
        end
    end

    assign boss_alive = (game_state == GAME_PLAY) && (health != '0);

    // pool only reports hits while the boss was alive a cycle earlier
    assert property (@(posedge clk) disable iff (rst)
        projectile_hit |-> $past(boss_alive))
        else $error("hit reported while boss was not alive");

endmodule

// ==== verilog/archer_pkg.sv ====
package archer_pkg;

    // screen coordinate, unsigned pixels
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } point_t;

    // one shot leaving the aim pipeline
    typedef struct packed {
        logic              valid;
        point_t            origin;
        logic signed [5:0] step_x;
        logic signed [5:0] step_y;
    } shot_t;

    typedef enum logic [1:0] {
        GAME_IDLE = 2'd0,
        GAME_PLAY = 2'd1,
        GAME_WON  = 2'd2
    } game_state_t;

endpackage

// ==== include/archer_settings.svh ====
`ifndef ARCHER_SETTINGS_SVH
`define ARCHER_SETTINGS_SVH

// visible playfield in pixels
`define ARCHER_SCREEN_W 1024
`define ARCHER_SCREEN_H 768

// half sizes of the boss hit box
`define ARCHER_BOSS_HALF_W 106
`define ARCHER_BOSS_HALF_H 95

// pixels per frame along the major axis
`define ARCHER_SPEED 16

// arrow lifetime in frames
`define ARCHER_LIFETIME 60

// frames between two accepted shots
`define ARCHER_COOLDOWN 15

// number of arrows in flight at once
`define ARCHER_SLOTS 4

// hits needed to win
`define ARCHER_BOSS_HEALTH 3

`endif
